/* tb.f */
verilog/gfx_geom_pkg.sv
verilog/gfx_mem_pkg.sv
verilog/gfx_cmd_dispatch.sv
verilog/gfx_rect_fill.sv
verilog/gfx_glyph_blit.sv
verilog/gfx_pixel_merge.sv
verilog/gfx_draw_top.sv
testbench/tb_gfx_draw.sv

/* testbench/tb_gfx_draw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_draw
    import gfx_geom_pkg::*, gfx_mem_pkg::*;
();

    logic        clk          = 1'b0;
    logic        rst_n;
    gfx_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    pix_wr_t     mem_wr;
    logic        mem_wr_valid;
    logic        mem_wr_ready;
    draw_done_t  done;

    integer      seed         = 32'ha16e4a3f;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;
    int          err_cnt      = 0;
    int          tests_run    = 0;
    logic        test_end     = 1'b0;
    int          test_exp     = 0;
    int          writes_base  = 0;
    int          total_writes = 0;
    logic        cmd_taken    = 1'b0;
    gfx_cmd_t    cmd_list [13];

    // Model of the command in flight on each engine
    int          rect_x0      = 0;
    int          rect_y0      = 0;
    int          rect_x1      = 0;
    int          rect_y1      = 0;
    rgb565_t     rect_col     = '0;
    logic [1:0]  rect_bank    = '0;
    int          rect_left    = 0;
    int          rect_owed    = 0;      // Done pulses still due
    int          glyph_x      = 0;
    int          glyph_y      = 0;
    rgb565_t     glyph_col    = '0;
    logic [1:0]  glyph_bank   = '0;
    logic [15:0] glyph_mask   = '0;
    int          glyph_owed   = 0;

    logic        wr_fire;
    logic        acc_rect;
    logic        acc_glyph;
    logic        wr_is_glyph;
    logic        wr_is_rect;
    fb_addr_t    glyph_exp_addr;
    int          wr_row;
    int          wr_col;

    gfx_draw_top gfx_draw_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .mem_wr       (mem_wr),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready),
        .done         (done)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////

    // Length left after clipping at the screen edge
    function automatic int clipped_span(int origin, int size, int limit);
        if (origin >= limit) begin
            return 0;
        end
        return ((origin + size < limit) ? origin + size : limit) - origin;
    endfunction

    function automatic logic [15:0] visible_bits(glyph_args_t g);
        logic [15:0] m;
        for (int i = 0; i < 16; i++) begin
            m[i] = (int'(g.x) + i % 4 < screen_width) && (int'(g.y) + i / 4 < screen_height);
        end
        return g.bitmap & m;
    endfunction

    function automatic int lowest_set(logic [15:0] m);
        for (int i = 0; i < 16; i++) begin
            if (m[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic fb_addr_t pixel_addr(logic [1:0] bank, int x, int y);
        fb_addr_t a;
        a.bank   = bank;
        a.offset = 22'(y * screen_width + x);
        return a;
    endfunction

    function automatic int cmd_writes(gfx_cmd_t c);
        case (c.op)
            op_rect: begin
                return clipped_span(c.payload.rect.x, c.payload.rect.width, screen_width) *
                       clipped_span(c.payload.rect.y, c.payload.rect.height, screen_height);
            end
            op_glyph: return $countones(visible_bits(c.payload.glyph));
            default:  return 0;
        endcase
    endfunction

    function automatic gfx_cmd_t make_rect(int x, int y, int w, int h, rgb565_t col,
                                           logic [1:0] bank);
        gfx_cmd_t c;
        c.op                  = op_rect;
        c.payload.rect.x      = coord_x_t'(x);
        c.payload.rect.y      = coord_y_t'(y);
        c.payload.rect.width  = coord_x_t'(w);
        c.payload.rect.height = coord_y_t'(h);
        c.payload.rect.colour = col;
        c.payload.rect.bank   = bank;
        return c;
    endfunction

    function automatic gfx_cmd_t make_glyph(int x, int y, rgb565_t col, logic [1:0] bank,
                                            logic [15:0] bitmap);
        gfx_cmd_t c;
        c.op                   = op_glyph;
        c.payload.glyph.x      = coord_x_t'(x);
        c.payload.glyph.y      = coord_y_t'(y);
        c.payload.glyph.colour = col;
        c.payload.glyph.bank   = bank;
        c.payload.glyph.bitmap = bitmap;
        c.payload.glyph.pad    = '0;
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Clock, memory stalls and model tracking
    //////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(negedge clk) begin
        mem_wr_ready = ($random(seed) & 3) != 0;    // Ready about three cycles in four
    end

    always_comb begin
        wr_fire        = mem_wr_valid && mem_wr_ready;
        acc_rect       = cmd_valid && cmd_ready && cmd.op == op_rect;
        acc_glyph      = cmd_valid && cmd_ready && cmd.op == op_glyph;
        glyph_exp_addr = pixel_addr(glyph_bank, glyph_x + lowest_set(glyph_mask) % 4,
                                    glyph_y + lowest_set(glyph_mask) / 4);
        wr_is_glyph    = glyph_mask != '0 && mem_wr.rgb == glyph_col;
        wr_is_rect     = !wr_is_glyph && rect_left != 0 && mem_wr.rgb == rect_col;
        wr_row         = int'(mem_wr.addr.offset) / screen_width;
        wr_col         = int'(mem_wr.addr.offset) % screen_width;
    end

    always @(posedge clk) begin
        cmd_taken    <= cmd_valid && cmd_ready;
        total_writes <= total_writes + int'(wr_fire);
        rect_owed    <= rect_owed + int'(acc_rect) - int'(done.rect);
        glyph_owed   <= glyph_owed + int'(acc_glyph) - int'(done.glyph);
        if (acc_rect) begin
            rect_x0   <= cmd.payload.rect.x;
            rect_y0   <= cmd.payload.rect.y;
            rect_x1   <= int'(cmd.payload.rect.x) +
                         clipped_span(cmd.payload.rect.x, cmd.payload.rect.width, screen_width);
            rect_y1   <= int'(cmd.payload.rect.y) +
                         clipped_span(cmd.payload.rect.y, cmd.payload.rect.height, screen_height);
            rect_col  <= cmd.payload.rect.colour;
            rect_bank <= cmd.payload.rect.bank;
            rect_left <= cmd_writes(cmd);
        end else if (wr_fire && wr_is_rect) begin
            rect_left <= rect_left - 1;
        end
        if (acc_glyph) begin
            glyph_x    <= cmd.payload.glyph.x;
            glyph_y    <= cmd.payload.glyph.y;
            glyph_col  <= cmd.payload.glyph.colour;
            glyph_bank <= cmd.payload.glyph.bank;
            glyph_mask <= visible_bits(cmd.payload.glyph);
        end else if (wr_fire && wr_is_glyph) begin
            glyph_mask[lowest_set(glyph_mask)] <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_write_owner: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire |-> wr_is_rect || wr_is_glyph
    ) else begin
        err_cnt = err_cnt + 1;
        $display("MISMATCH mem_wr.rgb got %h, rect %h, glyph %h",
                 $sampled(mem_wr.rgb), $sampled(rect_col), $sampled(glyph_col));
    end

    a_rect_place: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire && wr_is_rect |-> mem_wr.addr.bank == rect_bank &&
            wr_col >= rect_x0 && wr_col < rect_x1 && wr_row >= rect_y0 && wr_row < rect_y1
    ) else begin
        err_cnt = err_cnt + 1;
        $display("MISMATCH mem_wr.addr got %h, rect x %h..%h y %h..%h", $sampled(mem_wr.addr),
                 $sampled(rect_x0), $sampled(rect_x1), $sampled(rect_y0), $sampled(rect_y1));
    end

    a_glyph_place: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire && wr_is_glyph |-> mem_wr.addr == glyph_exp_addr
    ) else begin
        err_cnt = err_cnt + 1;
        $display("MISMATCH mem_wr.addr got %h, expected %h",
                 $sampled(mem_wr.addr), $sampled(glyph_exp_addr));
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_valid && !mem_wr_ready |=> mem_wr_valid && $stable(mem_wr)
    ) else begin
        err_cnt = err_cnt + 1;
        $display("MISMATCH mem_wr got %h while stalled on %h", $sampled(mem_wr), $past(mem_wr));
    end

    a_rect_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd.op == op_rect && rect_left != 0 |-> !cmd_ready
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Rect command offered ready while the rect engine still had writes");
    end

    a_glyph_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd.op == op_glyph && glyph_mask != '0 |-> !cmd_ready
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Glyph command offered ready while the glyph engine still had writes");
    end

    a_drop: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && (cmd.op == op_nop || cmd.op == op_rsvd) |-> cmd_ready
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Nop or reserved command was not taken at once");
    end

    a_rect_done: assert property (@(posedge clk) disable iff (!rst_n)
        done.rect |-> rect_owed != 0
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Rect done pulse with no rect command outstanding");
    end

    a_glyph_done: assert property (@(posedge clk) disable iff (!rst_n)
        done.glyph |-> glyph_owed != 0
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Glyph done pulse with no glyph command outstanding");
    end

    a_test_count: assert property (@(posedge clk) disable iff (!rst_n)
        test_end |-> total_writes - writes_base == test_exp
    ) else begin
        err_cnt = err_cnt + 1;
        $display("MISMATCH write count got %h, expected %h",
                 $sampled(total_writes - writes_base), $sampled(test_exp));
    end

    a_test_drain: assert property (@(posedge clk) disable iff (!rst_n)
        test_end |-> rect_left == 0 && glyph_mask == '0
    ) else begin
        err_cnt = err_cnt + 1;
        $display("Done pulses arrived while expected writes were still missing");
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_cmd(input gfx_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        test_exp  = test_exp + cmd_writes(c);
        do begin
            @(negedge clk);
        end while (!cmd_taken);
        cmd_valid = 1'b0;
    endtask

    task automatic begin_test();
        writes_base = total_writes;
        test_exp    = 0;
    endtask

    task automatic end_test(input string name);
        while (rect_owed != 0 || glyph_owed != 0) begin
            @(negedge clk);
        end
        test_end = 1'b1;
        @(negedge clk);
        test_end  = 1'b0;
        tests_run = tests_run + 1;
        $display("%-26s finished, %0d writes, errors so far %0d",
                 name, total_writes - writes_base, err_cnt);
    endtask

    initial begin
        int total;
        total        = 0;
        rst_n        = 1'b0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        mem_wr_ready = 1'b1;

        cmd_list[0]  = make_rect(10, 20, 5, 3, 16'hf800, 2'd2);
        cmd_list[1]  = make_rect(636, 478, 10, 10, 16'h07e0, 2'd1);
        cmd_list[2]  = make_rect(100, 100, 0, 7, 16'h001f, 2'd0);    // Zero width
        cmd_list[3]  = make_glyph(200, 50, 16'hffe0, 2'd3, 16'ha5c3);
        cmd_list[4]  = make_glyph(638, 30, 16'h7bef, 2'd1, 16'hffff);
        cmd_list[5]  = make_rect(20, 20, 4, 4, 16'h0f0f, 2'd0);
        cmd_list[5].op = op_nop;
        cmd_list[6]  = make_glyph(30, 30, 16'hf0f0, 2'd1, 16'hffff);
        cmd_list[6].op = op_rsvd;
        cmd_list[7]  = make_rect(300, 200, 6, 4, 16'h1234, 2'd0);
        cmd_list[8]  = make_glyph(302, 201, 16'h4321, 2'd0, 16'($random(seed)));
        cmd_list[9]  = make_rect(50, 60, 4, 4, 16'haaaa, 2'd3);
        cmd_list[10] = make_rect(52, 62, 3, 3, 16'hbbbb, 2'd3);
        cmd_list[11] = make_glyph(8, 8, 16'hcccc, 2'd2, 16'h9669);
        cmd_list[12] = make_glyph(637, 477, 16'hdddd, 2'd2, 16'hf00f);

        foreach (cmd_list[i]) begin
            total = total + cmd_writes(cmd_list[i]);
        end
        cycle_limit = total * 8 + 2000;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        begin_test();
        send_cmd(cmd_list[0]);
        end_test("rect on screen");

        begin_test();
        send_cmd(cmd_list[1]);
        send_cmd(cmd_list[2]);
        end_test("rect clipped and empty");

        begin_test();
        send_cmd(cmd_list[3]);
        send_cmd(cmd_list[4]);
        end_test("glyph and edge glyph");

        begin_test();
        send_cmd(cmd_list[5]);
        send_cmd(cmd_list[6]);
        repeat (8) @(negedge clk);  // Nothing should come out
        end_test("nop and reserved");

        begin_test();
        send_cmd(cmd_list[7]);
        send_cmd(cmd_list[8]);
        end_test("rect and glyph together");

        // Second command of each kind waits on the busy engine
        begin_test();
        send_cmd(cmd_list[9]);
        send_cmd(cmd_list[10]);
        send_cmd(cmd_list[11]);
        send_cmd(cmd_list[12]);
        end_test("busy engine blocks");

        $display("tests %0d, writes %0d, errors %0d", tests_run, total_writes, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/gfx_draw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_draw_top
    import gfx_geom_pkg::*, gfx_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  gfx_cmd_t   cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,

    output pix_wr_t    mem_wr,
    output logic       mem_wr_valid,
    input  logic       mem_wr_ready,

    output draw_done_t done
);

    gfx_payload_u payload;
    logic         rect_cmd_valid;
    logic         rect_cmd_ready;
    logic         glyph_cmd_valid;
    logic         glyph_cmd_ready;
    pix_wr_t      rect_pix;
    logic         rect_pix_valid;
    logic         rect_pix_ready;
    pix_wr_t      glyph_pix;
    logic         glyph_pix_valid;
    logic         glyph_pix_ready;
    logic         rect_done;
    logic         glyph_done;

    gfx_cmd_dispatch gfx_cmd_dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .payload     (payload),
        .rect_valid  (rect_cmd_valid),
        .rect_ready  (rect_cmd_ready),
        .glyph_valid (glyph_cmd_valid),
        .glyph_ready (glyph_cmd_ready)
    );

    gfx_rect_fill gfx_rect_fill_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .payload   (payload),
        .cmd_valid (rect_cmd_valid),
        .cmd_ready (rect_cmd_ready),
        .pix       (rect_pix),
        .pix_valid (rect_pix_valid),
        .pix_ready (rect_pix_ready),
        .done      (rect_done)
    );

    gfx_glyph_blit gfx_glyph_blit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .payload   (payload),
        .cmd_valid (glyph_cmd_valid),
        .cmd_ready (glyph_cmd_ready),
        .pix       (glyph_pix),
        .pix_valid (glyph_pix_valid),
        .pix_ready (glyph_pix_ready),
        .done      (glyph_done)
    );

    gfx_pixel_merge gfx_pixel_merge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rect_pix     (rect_pix),
        .rect_valid   (rect_pix_valid),
        .rect_ready   (rect_pix_ready),
        .glyph_pix    (glyph_pix),
        .glyph_valid  (glyph_pix_valid),
        .glyph_ready  (glyph_pix_ready),
        .mem_wr       (mem_wr),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready),
        .rect_done    (rect_done),
        .glyph_done   (glyph_done),
        .done         (done)
    );

endmodule

`default_nettype wire

/* verilog/gfx_pixel_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_pixel_merge
    import gfx_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  pix_wr_t    rect_pix,
    input  logic       rect_valid,
    output logic       rect_ready,
    input  pix_wr_t    glyph_pix,
    input  logic       glyph_valid,
    output logic       glyph_ready,

    output pix_wr_t    mem_wr,
    output logic       mem_wr_valid,
    input  logic       mem_wr_ready,

    input  logic       rect_done,
    input  logic       glyph_done,
    output draw_done_t done
);

    logic sel_glyph;
    logic last_glyph;   // Glyph won the last transfer
    logic locked;
    logic lock_glyph;

    //////////////////////////////////////////////////////////////////////
    // Round robin, grant held while the memory stalls
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (locked) begin
            sel_glyph = lock_glyph;
        end else if (rect_valid && glyph_valid) begin
            sel_glyph = !last_glyph;
        end else begin
            sel_glyph = glyph_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_glyph <= 1'b0;
            locked     <= 1'b0;
            lock_glyph <= 1'b0;
            done       <= '0;
        end else begin
            locked     <= mem_wr_valid && !mem_wr_ready;
            lock_glyph <= sel_glyph;
            if (mem_wr_valid && mem_wr_ready) begin
                last_glyph <= sel_glyph;
            end
            done.rect  <= rect_done;
            done.glyph <= glyph_done;
        end
    end

    assign mem_wr       = sel_glyph ? glyph_pix : rect_pix;
    assign mem_wr_valid = sel_glyph ? glyph_valid : rect_valid;
    assign rect_ready   = !sel_glyph && mem_wr_ready;
    assign glyph_ready  = sel_glyph && mem_wr_ready;

    a_one_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rect_ready && glyph_ready)
    );

endmodule

`default_nettype wire

/* verilog/gfx_glyph_blit.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_glyph_blit
    import gfx_geom_pkg::*, gfx_mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  gfx_payload_u payload,
    input  logic         cmd_valid,
    output logic         cmd_ready,

    output pix_wr_t      pix,
    output logic         pix_valid,
    input  logic         pix_ready,
    output logic         done
);

    glyph_args_t           args_q;
    logic [glyph_bits-1:0] mask;        // Set bits still to draw
    logic [glyph_bits-1:0] mask_new;
    logic [glyph_bits-1:0] mask_rest;
    logic [glyph_dim-1:0]  col_vis;
    logic [glyph_dim-1:0]  row_vis;
    logic [glyph_bits-1:0] vis;
    logic [3:0]            bit_idx;
    logic                  accept;
    logic                  xfer;

    assign cmd_ready = (mask == '0);
    assign pix_valid = (mask != '0);
    assign accept    = cmd_valid && cmd_ready;
    assign xfer      = pix_valid && pix_ready;

    // Which columns and rows of the cell land on screen
    always_comb begin
        for (int i = 0; i < glyph_dim; i++) begin
            col_vis[i] = ({1'b0, payload.glyph.x} + 11'(i)) < 11'(screen_width);
            row_vis[i] = ({1'b0, payload.glyph.y} + 10'(i)) < 10'(screen_height);
        end
        for (int i = 0; i < glyph_bits; i++) begin
            vis[i] = col_vis[i % glyph_dim] && row_vis[i / glyph_dim];
        end
    end

    assign mask_new = payload.glyph.bitmap & vis;

    // Lowest set bit goes first
    always_comb begin
        bit_idx = '0;
        for (int i = glyph_bits - 1; i >= 0; i--) begin
            if (mask[i]) begin
                bit_idx = 4'(i);
            end
        end
    end

    assign mask_rest = mask & ~(glyph_bits'(1) << bit_idx);

    always_ff @(posedge clk) begin
        if (accept) begin
            args_q <= payload.glyph;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                mask <= mask_new;
                done <= (mask_new == '0);   // Nothing visible
            end else if (xfer) begin
                mask <= mask_rest;
                done <= (mask_rest == '0);
            end
        end
    end

    assign pix.addr = fb_addr(args_q.bank, args_q.x + coord_x_t'(bit_idx[1:0]),
                              args_q.y + coord_y_t'(bit_idx[3:2]));
    assign pix.rgb  = args_q.colour;

    a_bit_set: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_valid |-> mask[bit_idx]
    );

endmodule

`default_nettype wire

/* verilog/gfx_rect_fill.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_rect_fill
    import gfx_geom_pkg::*, gfx_mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  gfx_payload_u payload,
    input  logic         cmd_valid,
    output logic         cmd_ready,

    output pix_wr_t      pix,
    output logic         pix_valid,
    input  logic         pix_ready,
    output logic         done
);

    rect_args_t  args_q;
    coord_x_t    w_clip;
    coord_y_t    h_clip;
    coord_x_t    dx;
    coord_y_t    dy;
    logic        busy;
    logic [10:0] x_sum;
    logic [9:0]  y_sum;
    logic [10:0] x_lim;
    logic [9:0]  y_lim;
    coord_x_t    w_new;
    coord_y_t    h_new;
    logic        accept;
    logic        xfer;

    assign cmd_ready = !busy;
    assign accept    = cmd_valid && cmd_ready;
    assign xfer      = pix_valid && pix_ready;

    // Clip right and bottom edges against the screen
    assign x_sum = {1'b0, payload.rect.x} + {1'b0, payload.rect.width};
    assign y_sum = {1'b0, payload.rect.y} + {1'b0, payload.rect.height};
    assign x_lim = (x_sum < 11'(screen_width)) ? x_sum : 11'(screen_width);
    assign y_lim = (y_sum < 10'(screen_height)) ? y_sum : 10'(screen_height);
    assign w_new = (payload.rect.x < screen_width) ? coord_x_t'(x_lim - {1'b0, payload.rect.x}) : '0;
    assign h_new = (payload.rect.y < screen_height) ? coord_y_t'(y_lim - {1'b0, payload.rect.y}) : '0;

    always_ff @(posedge clk) begin
        if (accept) begin
            args_q <= payload.rect;
            w_clip <= w_new;
            h_clip <= h_new;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            dx   <= '0;
            dy   <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                dx   <= '0;
                dy   <= '0;
                busy <= (w_new != '0) && (h_new != '0);
                done <= (w_new == '0) || (h_new == '0);   // Empty area
            end else if (xfer) begin
                if (dx == w_clip - 1'b1) begin
                    dx <= '0;
                    if (dy == h_clip - 1'b1) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        dy <= dy + 1'b1;
                    end
                end else begin
                    dx <= dx + 1'b1;
                end
            end
        end
    end

    assign pix_valid = busy;
    assign pix.addr  = fb_addr(args_q.bank, args_q.x + dx, args_q.y + dy);
    assign pix.rgb   = args_q.colour;

    a_in_screen: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_valid |-> (pix.addr.offset < fb_pixels)
    );

    a_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix)
    );

endmodule

`default_nettype wire

/* verilog/gfx_cmd_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_dispatch
    import gfx_geom_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  gfx_cmd_t     cmd,
    input  logic         cmd_valid,
    output logic         cmd_ready,

    output gfx_payload_u payload,
    output logic         rect_valid,
    input  logic         rect_ready,
    output logic         glyph_valid,
    input  logic         glyph_ready
);

    // Both engines see the same payload, valid picks the taker
    assign payload = cmd.payload;

    always_comb begin
        rect_valid  = 1'b0;
        glyph_valid = 1'b0;
        cmd_ready   = 1'b1;             // Nop and reserved just drain
        case (cmd.op)
            op_rect: begin
                rect_valid = cmd_valid;
                cmd_ready  = rect_ready;
            end
            op_glyph: begin
                glyph_valid = cmd_valid;
                cmd_ready   = glyph_ready;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_one_engine: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rect_valid && glyph_valid)
    );

endmodule

`default_nettype wire

/* verilog/gfx_mem_pkg.sv */
`default_nettype none

package gfx_mem_pkg;

    import gfx_geom_pkg::*;

    localparam int bank_w    = 2;
    localparam int fb_addr_w = 24;
    localparam int pix_off_w = fb_addr_w - bank_w;
    localparam int fb_pixels = screen_width * screen_height;

    // Bank on top, linear pixel offset below
    typedef struct packed {
        logic [bank_w-1:0]    bank;
        logic [pix_off_w-1:0] offset;
    } fb_addr_t;

    typedef struct packed {
        fb_addr_t addr;
        rgb565_t  rgb;
    } pix_wr_t;

    typedef struct packed {
        logic rect;
        logic glyph;
    } draw_done_t;

    function automatic fb_addr_t fb_addr(logic [bank_w-1:0] bank, coord_x_t x, coord_y_t y);
        fb_addr_t a;
        a.bank   = bank;
        a.offset = pix_off_w'(y) * pix_off_w'(screen_width) + pix_off_w'(x);
        return a;
    endfunction

endpackage

`default_nettype wire

/* verilog/gfx_geom_pkg.sv */
`default_nettype none

package gfx_geom_pkg;

    //////////////////////////////////////////////////////////////////////
    // Screen geometry
    //////////////////////////////////////////////////////////////////////

    localparam int screen_width  = 640;
    localparam int screen_height = 480;

    localparam int glyph_dim  = 4;                      // Glyph is 4x4 cells
    localparam int glyph_bits = glyph_dim * glyph_dim;

    typedef logic [9:0]  coord_x_t;
    typedef logic [8:0]  coord_y_t;
    typedef logic [15:0] rgb565_t;

    typedef enum logic [1:0] {
        op_nop   = 2'd0,
        op_rect  = 2'd1,
        op_glyph = 2'd2,
        op_rsvd  = 2'd3
    } gfx_op_e;

    //////////////////////////////////////////////////////////////////////
    // Command payload, 56 bits in either view
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        coord_x_t   x;
        coord_y_t   y;
        coord_x_t   width;
        coord_y_t   height;
        rgb565_t    colour;
        logic [1:0] bank;
    } rect_args_t;

    // Bitmap bit i sits at row i/4, column i%4
    typedef struct packed {
        coord_x_t              x;
        coord_y_t              y;
        rgb565_t               colour;
        logic [1:0]            bank;
        logic [glyph_bits-1:0] bitmap;
        logic [2:0]            pad;
    } glyph_args_t;

    typedef union packed {
        rect_args_t  rect;
        glyph_args_t glyph;
    } gfx_payload_u;

    typedef struct packed {
        gfx_op_e      op;
        gfx_payload_u payload;
    } gfx_cmd_t;

endpackage

`default_nettype wire
